//--- design/decode_stage.sv
`default_nettype none
`include "rv_consts.svh"

module decode_stage (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             if_valid_i,
    input  logic [`XLEN-1:0] if_pc_i,
    input  rv_pkg::instr_u   if_instr_i,
    input  logic             flush_i,
    input  logic             wb_wren_i,
    input  logic [4:0]       wb_rd_i,
    input  logic [`XLEN-1:0] wb_data_i,
    id_ex_if.src             ex,
    output logic [`XLEN-1:0] pc_decoding_o
);

    // x0 has no storage
    logic [`XLEN-1:0] regs [31:1];

    logic [4:0]       rs1_idx;
    logic [4:0]       rs2_idx;
    logic [6:0]       opcode;
    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
    logic [`XLEN-1:0] imm;

    assign rs1_idx = if_instr_i.r.rs1;
    assign rs2_idx = if_instr_i.r.rs2;
    assign opcode  = if_instr_i.r.opcode;

    assign pc_decoding_o = if_pc_i;

    // register file write from writeback
    always_ff @(posedge clk_i) begin
        if (wb_wren_i) begin
            regs[wb_rd_i] <= wb_data_i;
        end
    end

    // reads see a write landing in the same cycle
    assign rs1_val = (rs1_idx == 5'd0) ? '0 :
                     (wb_wren_i && (wb_rd_i == rs1_idx)) ? wb_data_i :
                     regs[rs1_idx];

    assign rs2_val = (rs2_idx == 5'd0) ? '0 :
                     (wb_wren_i && (wb_rd_i == rs2_idx)) ? wb_data_i :
                     regs[rs2_idx];

    // immediate by instruction format
    always_comb begin
        case (opcode)
            `OP_LUI, `OP_AUIPC: begin
                imm = {if_instr_i.u.imm_31_12, 12'b0};
            end
            `OP_JAL: begin
                imm = {{11{if_instr_i.j.imm_20}},
                       if_instr_i.j.imm_20,
                       if_instr_i.j.imm_19_12,
                       if_instr_i.j.imm_11,
                       if_instr_i.j.imm_10_1,
                       1'b0};
            end
            `OP_BRANCH: begin
                imm = {{19{if_instr_i.b.imm_12}},
                       if_instr_i.b.imm_12,
                       if_instr_i.b.imm_11,
                       if_instr_i.b.imm_10_5,
                       if_instr_i.b.imm_4_1,
                       1'b0};
            end
            `OP_STORE: begin
                imm = {{20{if_instr_i.s.imm_11_5[6]}},
                       if_instr_i.s.imm_11_5,
                       if_instr_i.s.imm_4_0};
            end
            default: begin
                // i-type: op-imm, load, jalr
                imm = {{20{if_instr_i.i.imm_11_0[11]}}, if_instr_i.i.imm_11_0};
            end
        endcase
    end

    // id/ex valid, dropped when execute redirects
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex.valid <= 1'b0;
        end else begin
            ex.valid <= if_valid_i && !flush_i;
        end
    end

    // id/ex payload
    always_ff @(posedge clk_i) begin
        ex.pc      <= if_pc_i;
        ex.instr   <= if_instr_i;
        ex.rs1_val <= rs1_val;
        ex.rs2_val <= rs2_val;
        ex.imm     <= imm;
    end

    // writeback must filter rd == 0 before it gets here
    a_no_x0_write: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        wb_wren_i |-> (wb_rd_i != 5'd0)
    );

endmodule

`default_nettype wire

//--- design/execute_stage.sv
`default_nettype none
`include "rv_consts.svh"

module execute_stage (
    input  logic             clk_i,
    input  logic             rst_n_i,
    id_ex_if.dst             id,
    ex_mem_if.src            mem,
    output logic             redirect_o,
    output logic [`XLEN-1:0] redirect_pc_o
);

    import rv_pkg::*;

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic             funct7_b5;
    logic             is_branch;
    logic             is_jal;
    logic             is_jalr;
    alu_op_e          alu_op;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [4:0]       shamt;
    logic [`XLEN-1:0] alu_res;
    logic             br_cond;
    logic [`XLEN-1:0] pc_plus4;
    logic [`XLEN-1:0] branch_target;

    assign opcode    = id.instr.r.opcode;
    assign funct3    = id.instr.r.funct3;
    assign funct7_b5 = id.instr.r.funct7[5];
    assign is_branch = (opcode == `OP_BRANCH);
    assign is_jal    = (opcode == `OP_JAL);
    assign is_jalr   = (opcode == `OP_JALR);

    // pc only feeds the alu for auipc
    assign op_a  = (opcode == `OP_AUIPC) ? id.pc : id.rs1_val;
    assign op_b  = (opcode == `OP_REG) ? id.rs2_val : id.imm;
    assign shamt = op_b[4:0];

    always_comb begin
        alu_op = ALU_ADD;
        if (opcode == `OP_LUI) begin
            alu_op = ALU_COPY_B;
        end else if (opcode == `OP_IMM || opcode == `OP_REG) begin
            case (funct3)
                // sub only exists in the register form
                3'b000:  alu_op = (opcode == `OP_REG && funct7_b5) ? ALU_SUB : ALU_ADD;
                3'b001:  alu_op = ALU_SLL;
                3'b010:  alu_op = ALU_SLT;
                3'b011:  alu_op = ALU_SLTU;
                3'b100:  alu_op = ALU_XOR;
                3'b101:  alu_op = funct7_b5 ? ALU_SRA : ALU_SRL;
                3'b110:  alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end
    end

    always_comb begin
        case (alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_SLL:    alu_res = op_a << shamt;
            ALU_SLT:    alu_res = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_res = {{(`XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SRL:    alu_res = op_a >> shamt;
            ALU_SRA:    alu_res = $signed(op_a) >>> shamt;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_AND:    alu_res = op_a & op_b;
            default:    alu_res = op_b;
        endcase
    end

    // branch condition on the two register values
    always_comb begin
        case (funct3)
            3'b000:  br_cond = (id.rs1_val == id.rs2_val);
            3'b001:  br_cond = (id.rs1_val != id.rs2_val);
            3'b100:  br_cond = ($signed(id.rs1_val) < $signed(id.rs2_val));
            3'b101:  br_cond = ($signed(id.rs1_val) >= $signed(id.rs2_val));
            3'b110:  br_cond = (id.rs1_val < id.rs2_val);
            3'b111:  br_cond = (id.rs1_val >= id.rs2_val);
            default: br_cond = 1'b0;
        endcase
    end

    assign pc_plus4      = id.pc + `XLEN'd4;
    assign branch_target = id.pc + id.imm;

    assign redirect_o    = id.valid && ((is_branch && br_cond) || is_jal || is_jalr);
    // jalr target is rs1 + imm with bit 0 cleared
    assign redirect_pc_o = is_jalr ? {alu_res[`XLEN-1:1], 1'b0} : branch_target;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem.valid <= 1'b0;
        end else begin
            mem.valid <= id.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        mem.pc         <= id.pc;
        mem.instr      <= id.instr;
        mem.result     <= (is_jal || is_jalr) ? pc_plus4 : alu_res;
        mem.store_data <= id.rs2_val;
    end

    // decode flush leaves a bubble behind every redirect
    a_redirect_bubble: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        redirect_o |=> !redirect_o
    );

endmodule

`default_nettype wire

//--- design/fetch_stage.sv
`default_nettype none
`include "rv_consts.svh"

module fetch_stage (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             imem_we_i,
    input  logic [`XLEN-1:0] imem_addr_i,
    input  logic [`XLEN-1:0] imem_wdata_i,
    input  logic             redirect_i,
    input  logic [`XLEN-1:0] redirect_pc_i,
    output logic             if_valid_o,
    output logic [`XLEN-1:0] if_pc_o,
    output rv_pkg::instr_u   if_instr_o
);

    localparam int IMEM_AW = $clog2(`IMEM_WORDS);

    logic [`XLEN-1:0]   pc_q;
    logic [`XLEN-1:0]   imem [`IMEM_WORDS];
    logic [IMEM_AW-1:0] fetch_idx;
    logic [IMEM_AW-1:0] load_idx;

    // word addressed, byte offset dropped
    assign fetch_idx = pc_q[IMEM_AW+1:2];
    assign load_idx  = imem_addr_i[IMEM_AW+1:2];

    // program load port
    always_ff @(posedge clk_i) begin
        if (imem_we_i) begin
            imem[load_idx] <= imem_wdata_i;
        end
    end

    // pc and if/id valid
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q       <= `RESET_PC;
            if_valid_o <= 1'b0;
        end else if (redirect_i) begin
            // word under fetch this cycle is on the wrong path
            pc_q       <= redirect_pc_i;
            if_valid_o <= 1'b0;
        end else begin
            pc_q       <= pc_q + `XLEN'd4;
            if_valid_o <= 1'b1;
        end
    end

    // if/id payload
    always_ff @(posedge clk_i) begin
        if_pc_o    <= pc_q;
        if_instr_o <= imem[fetch_idx];
    end

    // a bad jalr or branch target from execute lands here
    a_pc_aligned: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        pc_q[1:0] == 2'b00
    );

endmodule

`default_nettype wire

//--- design/mem_wb_stage.sv
`default_nettype none
`include "rv_consts.svh"

module mem_wb_stage (
    input  logic             clk_i,
    input  logic             rst_n_i,
    ex_mem_if.dst            ex,
    output logic             wb_wren_o,
    output logic [4:0]       wb_rd_o,
    output logic [`XLEN-1:0] wb_data_o,
    output logic             retire_valid_o,
    output logic [`XLEN-1:0] retire_pc_o,
    output logic [4:0]       retire_rd_o,
    output logic             retire_wren_o,
    output logic [`XLEN-1:0] retire_data_o
);

    import rv_pkg::*;

    localparam int DMEM_AW = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0]   dmem [`DMEM_WORDS];
    logic [DMEM_AW-1:0] dmem_idx;
    logic               is_load;
    logic               is_store;

    logic               wb_valid_q;
    logic [`XLEN-1:0]   wb_pc_q;
    instr_u             wb_instr_q;
    logic [`XLEN-1:0]   wb_data_q;
    logic               wb_writes_rd;

    assign is_load  = (ex.instr.r.opcode == `OP_LOAD);
    assign is_store = (ex.instr.r.opcode == `OP_STORE);
    assign dmem_idx = ex.result[DMEM_AW+1:2];

    // word store only
    always_ff @(posedge clk_i) begin
        if (ex.valid && is_store) begin
            dmem[dmem_idx] <= ex.store_data;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= ex.valid;
        end
    end

    // mem/wb payload, load data picked here
    always_ff @(posedge clk_i) begin
        wb_pc_q    <= ex.pc;
        wb_instr_q <= ex.instr;
        wb_data_q  <= is_load ? dmem[dmem_idx] : ex.result;
    end

    // branches and stores have no rd
    assign wb_writes_rd = (wb_instr_q.r.opcode != `OP_BRANCH) &&
                          (wb_instr_q.r.opcode != `OP_STORE);

    assign wb_rd_o   = wb_instr_q.r.rd;
    assign wb_wren_o = wb_valid_q && wb_writes_rd && (wb_instr_q.r.rd != 5'd0);
    assign wb_data_o = wb_data_q;

    // retire record mirrors the writeback
    assign retire_valid_o = wb_valid_q;
    assign retire_pc_o    = wb_pc_q;
    assign retire_rd_o    = wb_instr_q.r.rd;
    assign retire_wren_o  = wb_wren_o;
    assign retire_data_o  = wb_data_q;

    // address comes from the execute adder
    a_mem_aligned: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (ex.valid && (is_load || is_store)) |-> (ex.result[1:0] == 2'b00)
    );

endmodule

`default_nettype wire

//--- design/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// datapath and address width
`define XLEN        32

// memory depths, in 32-bit words
`define IMEM_WORDS  64
`define DMEM_WORDS  64

// first fetch address out of reset
`define RESET_PC    32'h0000_0000

// rv32i major opcodes
`define OP_LUI      7'b0110111
`define OP_AUIPC    7'b0010111
`define OP_JAL      7'b1101111
`define OP_JALR     7'b1100111
`define OP_BRANCH   7'b1100011
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_IMM      7'b0010011
`define OP_REG      7'b0110011

`endif

//--- design/rv_core_top.sv
`default_nettype none
`include "rv_consts.svh"

module rv_core_top (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             imem_we_i,
    input  logic [`XLEN-1:0] imem_addr_i,
    input  logic [`XLEN-1:0] imem_wdata_i,
    output logic [`XLEN-1:0] pc_decoding_o,
    output logic             retire_valid_o,
    output logic [`XLEN-1:0] retire_pc_o,
    output logic [4:0]       retire_rd_o,
    output logic             retire_wren_o,
    output logic [`XLEN-1:0] retire_data_o
);

    import rv_pkg::*;

    // if/id
    logic             if_valid;
    logic [`XLEN-1:0] if_pc;
    instr_u           if_instr;

    // redirect from execute
    logic             redirect;
    logic [`XLEN-1:0] redirect_pc;

    // writeback to the register file
    logic             wb_wren;
    logic [4:0]       wb_rd;
    logic [`XLEN-1:0] wb_data;

    id_ex_if  id_ex_bus ();
    ex_mem_if ex_mem_bus ();

    fetch_stage fetch_stage_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .imem_we_i     (imem_we_i),
        .imem_addr_i   (imem_addr_i),
        .imem_wdata_i  (imem_wdata_i),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .if_valid_o    (if_valid),
        .if_pc_o       (if_pc),
        .if_instr_o    (if_instr)
    );

    decode_stage decode_stage_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .if_valid_i    (if_valid),
        .if_pc_i       (if_pc),
        .if_instr_i    (if_instr),
        .flush_i       (redirect),
        .wb_wren_i     (wb_wren),
        .wb_rd_i       (wb_rd),
        .wb_data_i     (wb_data),
        .ex            (id_ex_bus.src),
        .pc_decoding_o (pc_decoding_o)
    );

    execute_stage execute_stage_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .id            (id_ex_bus.dst),
        .mem           (ex_mem_bus.src),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc)
    );

    mem_wb_stage mem_wb_stage_i (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .ex             (ex_mem_bus.dst),
        .wb_wren_o      (wb_wren),
        .wb_rd_o        (wb_rd),
        .wb_data_o      (wb_data),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .retire_rd_o    (retire_rd_o),
        .retire_wren_o  (retire_wren_o),
        .retire_data_o  (retire_data_o)
    );

endmodule

`default_nettype wire

//--- design/rv_pipe_ifs.sv
`default_nettype none
`include "rv_consts.svh"

// decode to execute
interface id_ex_if;
    import rv_pkg::*;

    logic             valid;
    logic [`XLEN-1:0] pc;
    instr_u           instr;
    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
    logic [`XLEN-1:0] imm;

    modport src (output valid, pc, instr, rs1_val, rs2_val, imm);
    modport dst (input  valid, pc, instr, rs1_val, rs2_val, imm);
endinterface

// execute to memory
interface ex_mem_if;
    import rv_pkg::*;

    logic             valid;
    logic [`XLEN-1:0] pc;
    instr_u           instr;
    // address for loads and stores, link value for jumps
    logic [`XLEN-1:0] result;
    logic [`XLEN-1:0] store_data;

    modport src (output valid, pc, instr, result, store_data);
    modport dst (input  valid, pc, instr, result, store_data);
endinterface

`default_nettype wire

//--- design/rv_pkg.sv
`default_nettype none

package rv_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, seen through each encoding format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_COPY_B
    } alu_op_e;

endpackage

`default_nettype wire

//--- flist.f
+incdir+design
design/rv_pkg.sv
design/rv_pipe_ifs.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/mem_wb_stage.sv
design/rv_core_top.sv
tb/tb_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -f sim.log
verilator --binary --assert --top-module tb_top -f flist.f -o tb_top_sim
./obj_dir/tb_top_sim 2>&1 | tee sim.log

if grep -q "TEST PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

//--- tb/rv_patterns.hex
// first word is the program length, then the program words from address 0
// then retire records with columns pc wren rd data, ended by ffffffff
33
00500093 ffd00113 123451b7 00001217 002082b3 40208333 00708013 0f014393
00112433 001134b3 00509533 40115593 01c15613 0060e6b3 00317733 001007b3
00602823 01002803 00208463 00f08663 00100f93 00100f93 00f09463 00209663
00100f93 00100f93 0020c463 00114663 00100f93 00100f93 00115463 00f0d663
00100f93 00100f93 00116463 0020e663 00100f93 00100f93 0020f463 00117663
00100f93 00100f93 00c008ef 00100f93 00100f93 01588967 00100f93 00100f93
012889b3 00180a13 0000006f
00000000 1 01 00000005    00000004 1 02 fffffffd
00000008 1 03 12345000    0000000c 1 04 0000100c
00000010 1 05 00000002    00000014 1 06 00000008
00000018 0 00 00000000    0000001c 1 07 ffffff0d
00000020 1 08 00000001    00000024 1 09 00000000
00000028 1 0a 00000014    0000002c 1 0b fffffffe
00000030 1 0c 0000000f    00000034 1 0d 0000000d
00000038 1 0e 12345000    0000003c 1 0f 00000005
00000040 0 00 00000000    00000044 1 10 00000008
00000048 0 00 00000000    0000004c 0 00 00000000
00000058 0 00 00000000    0000005c 0 00 00000000
00000068 0 00 00000000    0000006c 0 00 00000000
00000078 0 00 00000000    0000007c 0 00 00000000
00000088 0 00 00000000    0000008c 0 00 00000000
00000098 0 00 00000000    0000009c 0 00 00000000
000000a8 1 11 000000ac    000000b4 1 12 000000b8
000000c0 1 13 00000164    000000c4 1 14 00000009
000000c8 0 00 00000000
ffffffff

//--- tb/tb_top.sv
`default_nettype none
`include "rv_consts.svh"

module tb_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PAT_WORDS    = 256;
    localparam int RESET_CYCLES = 10;

    logic             clk = 1'b0;
    logic             rst_n;
    logic             imem_we;
    logic [`XLEN-1:0] imem_addr;
    logic [`XLEN-1:0] imem_wdata;
    logic [`XLEN-1:0] pc_decoding;
    logic             retire_valid;
    logic [`XLEN-1:0] retire_pc;
    logic [4:0]       retire_rd;
    logic             retire_wren;
    logic [`XLEN-1:0] retire_data;

    // word count, program, then 4-word retire records
    logic [31:0] pat [PAT_WORDS];
    int          prog_words;
    int          rec_base;
    int          rec_count;
    int          rec_idx;
    bit          run_started;

    // decode pc of the last three cycles, oldest in d3
    logic [`XLEN-1:0] dec_pc_d1;
    logic [`XLEN-1:0] dec_pc_d2;
    logic [`XLEN-1:0] dec_pc_d3;

    rv_core_top rv_core_top_i (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .imem_we_i      (imem_we),
        .imem_addr_i    (imem_addr),
        .imem_wdata_i   (imem_wdata),
        .pc_decoding_o  (pc_decoding),
        .retire_valid_o (retire_valid),
        .retire_pc_o    (retire_pc),
        .retire_rd_o    (retire_rd),
        .retire_wren_o  (retire_wren),
        .retire_data_o  (retire_data)
    );

    always #4 clk = ~clk;

    task automatic check_val(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error at time %0t: %s = %h, expected %h", $time, name, actual, expected);
            $display("TEST FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic read_patterns;
        int idx;
        $readmemh("tb/rv_patterns.hex", pat);
        prog_words = pat[0];
        rec_base   = prog_words + 1;
        idx        = rec_base;
        // walk records up to the end marker
        while (idx < PAT_WORDS && pat[idx] !== 32'hFFFF_FFFF) begin
            idx = idx + 4;
        end
        if (prog_words == 0 || prog_words > `IMEM_WORDS || idx >= PAT_WORDS) begin
            $display("the pattern file is malformed or has no end marker");
            $display("TEST FAIL");
            $fatal(1, "bad pattern file");
        end
        rec_count = (idx - rec_base) / 4;
    endtask

    // program goes in while the core is held in reset
    task automatic write_program;
        for (int i = 0; i < prog_words; i++) begin
            @(negedge clk);
            check_val("retire_valid_o during reset", {31'b0, retire_valid}, 32'd0);
            imem_we    = 1'b1;
            imem_addr  = i * 4;
            imem_wdata = pat[i + 1];
        end
        @(negedge clk);
        imem_we = 1'b0;
    endtask

    task automatic check_record(input int n);
        int base;
        base = rec_base + 4 * n;
        if (n == 0) begin
            check_val("first retire_pc_o", retire_pc, `RESET_PC);
        end
        check_val("retire_pc_o", retire_pc, pat[base]);
        // the retiring instruction sat in decode three cycles ago
        check_val("pc_decoding_o", dec_pc_d3, pat[base]);
        check_val("retire_wren_o", {31'b0, retire_wren}, pat[base + 1]);
        // rd and data only mean something when the register file is written
        if (pat[base + 1][0]) begin
            check_val("retire_rd_o", {27'b0, retire_rd}, pat[base + 2]);
            check_val("retire_data_o", retire_data, pat[base + 3]);
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        imem_we     = 1'b0;
        imem_addr   = '0;
        imem_wdata  = '0;
        run_started = 1'b0;
        rec_idx     = 0;
        read_patterns();
        write_program();
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_val("retire_valid_o during reset", {31'b0, retire_valid}, 32'd0);
        end
        rst_n       = 1'b1;
        run_started = 1'b1;
        // outputs move on the rising edge, so look at them mid-cycle
        while (rec_idx < rec_count) begin
            @(negedge clk);
            if (retire_valid) begin
                check_record(rec_idx);
                rec_idx = rec_idx + 1;
            end
            dec_pc_d3 = dec_pc_d2;
            dec_pc_d2 = dec_pc_d1;
            dec_pc_d1 = pc_decoding;
        end
        $display("TEST PASS");
        $finish;
    end

    // budget grows with the number of expected retires
    initial begin
        wait (run_started);
        repeat (rec_count * 20 + 50) @(posedge clk);
        $display("retirement stalled, only %0d of %0d records retired before the timeout",
                 rec_idx, rec_count);
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire
